// ==== src/frogger_pkg.sv ====
package frogger_pkg;

    // Screen coordinate, wide enough for 320 columns
    typedef logic [8:0] coord_t;

    // One bit each of red, green and blue
    typedef logic [2:0] color_t;

    // Rectangle selected by a draw command
    typedef enum logic [2:0] {
        TGT_SCRN_START,
        TGT_SCRN_GAME_OVER,
        TGT_GAME_BG,
        TGT_RIVER_1,
        TGT_RIVER_2,
        TGT_RIVER_3,
        TGT_FROG
    } draw_target_e;

    // Frog size in pixels
    localparam coord_t FROG_W = 9'd32;
    localparam coord_t FROG_H = 9'd24;

    // River object size in pixels
    localparam coord_t RIVER_W = 9'd96;
    localparam coord_t RIVER_H = 9'd30;

    // Top row of each river lane
    localparam coord_t RIVER_1_Y = 9'd75;
    localparam coord_t RIVER_2_Y = 9'd115;
    localparam coord_t RIVER_3_Y = 9'd155;

    // Full screen colors
    localparam color_t COLOR_START = 3'h4;
    localparam color_t COLOR_GAME_OVER = 3'h1;
    localparam color_t COLOR_BG = 3'h2;

    // All three river objects share one color
    localparam color_t COLOR_RIVER = 3'h6;

    // Frog color
    localparam color_t COLOR_FROG = 3'h3;

endpackage

// ==== src/draw_cmd_if.sv ====
`timescale 1ns/100ps

interface draw_cmd_if;

    // One cycle pulse, setup cycle of a draw
    logic start;
    // High for every pixel cycle of a draw
    logic active;
    // Rectangle being drawn, constant over a draw
    frogger_pkg::draw_target_e target;
    // Last pixel cycle of a draw
    logic done;

    // Scene FSM issues commands and waits for done
    modport sequencer (output start, output active, output target, input done);

    // Object store only needs to know when and what to move
    modport store (input start, input target);

    // Rasterizer scans the rectangle and reports the end
    modport rasterizer (input start, input active, output done);

endinterface

// ==== src/rect_if.sv ====
`timescale 1ns/100ps

interface rect_if;

    // Top left corner of the rectangle
    frogger_pkg::coord_t origin_x;
    frogger_pkg::coord_t origin_y;

    // Size in pixels
    frogger_pkg::coord_t width;
    frogger_pkg::coord_t height;

    // Solid fill color
    frogger_pkg::color_t color;

    // Object store side
    modport source (output origin_x, output origin_y, output width, output height,
                    output color);

    // Rasterizer side
    modport sink (input origin_x, input origin_y, input width, input height,
                  input color);

endinterface

// ==== src/scene_sequencer.sv ====
`timescale 1ns/100ps

module scene_sequencer (
    input logic           clk,
    input logic           reset,
    input logic           go_key,
    draw_cmd_if.sequencer cmd
);

    // Go key shaper, two cycle pulse then wait for release
    typedef enum logic [1:0] {
        GS_WAIT_GO,
        GS_GO_1,
        GS_GO_2,
        GS_WAIT
    } go_state_e;

    // Scene FSM, a setup state ahead of every draw state
    typedef enum logic [4:0] {
        S_WAIT_START,
        S_SETUP_START,
        S_DRAW_START,
        S_WAIT_GAME_OVER,
        S_SETUP_GAME_OVER,
        S_DRAW_GAME_OVER,
        S_WAIT_BG,
        S_SETUP_BG,
        S_DRAW_BG,
        S_SETUP_RIVER_1,
        S_DRAW_RIVER_1,
        S_SETUP_RIVER_2,
        S_DRAW_RIVER_2,
        S_SETUP_RIVER_3,
        S_DRAW_RIVER_3,
        S_SETUP_FROG,
        S_DRAW_FROG
    } scene_state_e;

    go_state_e                 go_state;
    go_state_e                 go_next;
    logic                      go;
    scene_state_e              state;
    scene_state_e              next_state;
    logic                      setup_c;
    logic                      draw_c;
    frogger_pkg::draw_target_e target_c;

    always_comb begin
        case (go_state)
            GS_WAIT_GO: go_next = go_key ? GS_GO_1 : GS_WAIT_GO;
            GS_GO_1:    go_next = GS_GO_2;
            GS_GO_2:    go_next = GS_WAIT;
            default:    go_next = go_key ? GS_WAIT : GS_WAIT_GO;
        endcase
    end

    assign go = (go_state == GS_GO_1) || (go_state == GS_GO_2);

    // Only the three wait states look at go
    always_comb begin
        next_state = state;
        case (state)
            S_WAIT_START:      if (go) next_state = S_SETUP_START;
            S_SETUP_START:     next_state = S_DRAW_START;
            S_DRAW_START:      if (cmd.done) next_state = S_WAIT_GAME_OVER;
            S_WAIT_GAME_OVER:  if (go) next_state = S_SETUP_GAME_OVER;
            S_SETUP_GAME_OVER: next_state = S_DRAW_GAME_OVER;
            S_DRAW_GAME_OVER:  if (cmd.done) next_state = S_WAIT_BG;
            S_WAIT_BG:         if (go) next_state = S_SETUP_BG;
            S_SETUP_BG:        next_state = S_DRAW_BG;
            S_DRAW_BG:         if (cmd.done) next_state = S_SETUP_RIVER_1;
            S_SETUP_RIVER_1:   next_state = S_DRAW_RIVER_1;
            S_DRAW_RIVER_1:    if (cmd.done) next_state = S_SETUP_RIVER_2;
            S_SETUP_RIVER_2:   next_state = S_DRAW_RIVER_2;
            S_DRAW_RIVER_2:    if (cmd.done) next_state = S_SETUP_RIVER_3;
            S_SETUP_RIVER_3:   next_state = S_DRAW_RIVER_3;
            S_DRAW_RIVER_3:    if (cmd.done) next_state = S_SETUP_FROG;
            S_SETUP_FROG:      next_state = S_DRAW_FROG;
            // Endless game loop
            S_DRAW_FROG:       if (cmd.done) next_state = S_SETUP_BG;
            default:           next_state = S_WAIT_START;
        endcase
    end

    // State decode for the command outputs
    always_comb begin
        setup_c = state inside {S_SETUP_START, S_SETUP_GAME_OVER, S_SETUP_BG,
                                S_SETUP_RIVER_1, S_SETUP_RIVER_2, S_SETUP_RIVER_3,
                                S_SETUP_FROG};
        draw_c  = state inside {S_DRAW_START, S_DRAW_GAME_OVER, S_DRAW_BG,
                                S_DRAW_RIVER_1, S_DRAW_RIVER_2, S_DRAW_RIVER_3,
                                S_DRAW_FROG};
        case (state)
            S_SETUP_GAME_OVER, S_DRAW_GAME_OVER: target_c = frogger_pkg::TGT_SCRN_GAME_OVER;
            S_SETUP_BG, S_DRAW_BG:               target_c = frogger_pkg::TGT_GAME_BG;
            S_SETUP_RIVER_1, S_DRAW_RIVER_1:     target_c = frogger_pkg::TGT_RIVER_1;
            S_SETUP_RIVER_2, S_DRAW_RIVER_2:     target_c = frogger_pkg::TGT_RIVER_2;
            S_SETUP_RIVER_3, S_DRAW_RIVER_3:     target_c = frogger_pkg::TGT_RIVER_3;
            S_SETUP_FROG, S_DRAW_FROG:           target_c = frogger_pkg::TGT_FROG;
            default:                             target_c = frogger_pkg::TGT_SCRN_START;
        endcase
    end

    // Command outputs lag the state by one cycle
    // This leaves one idle cycle after done before the next start
    always_ff @(posedge clk) begin
        if (reset) begin
            go_state   <= GS_WAIT_GO;
            state      <= S_WAIT_START;
            cmd.start  <= 1'b0;
            cmd.active <= 1'b0;
            cmd.target <= frogger_pkg::TGT_SCRN_START;
        end else begin
            go_state   <= go_next;
            state      <= next_state;
            cmd.start  <= setup_c;
            // Drop active right after the last pixel
            cmd.active <= draw_c && !cmd.done;
            cmd.target <= target_c;
        end
    end

endmodule

// ==== src/object_store.sv ====
`timescale 1ns/100ps

module object_store #(
    parameter int SCREEN_W = 320,
    parameter int SCREEN_H = 240
) (
    input logic       clk,
    input logic       reset,
    input logic       key_left,
    input logic       key_right,
    input logic       key_up,
    input logic       key_down,
    draw_cmd_if.store cmd,
    rect_if.source    rect
);

    // Largest frog origin that keeps it on screen
    localparam int FROG_X_MAX = SCREEN_W - int'(frogger_pkg::FROG_W);
    localparam int FROG_Y_MAX = SCREEN_H - int'(frogger_pkg::FROG_H);
    localparam frogger_pkg::coord_t X_LAST = frogger_pkg::coord_t'(SCREEN_W - 1);

    frogger_pkg::coord_t frog_x;
    frogger_pkg::coord_t frog_y;
    frogger_pkg::coord_t river_1_x;
    frogger_pkg::coord_t river_2_x;
    frogger_pkg::coord_t river_3_x;
    logic signed [9:0]   frog_x_step;
    logic signed [9:0]   frog_y_step;
    logic                frog_x_ok;
    logic                frog_y_ok;

    // River drift, wrapping around the screen width
    function automatic frogger_pkg::coord_t wrap_inc(frogger_pkg::coord_t v);
        return (v == X_LAST) ? '0 : v + 9'd1;
    endfunction

    function automatic frogger_pkg::coord_t wrap_dec(frogger_pkg::coord_t v);
        return (v == '0) ? X_LAST : v - 9'd1;
    endfunction

    // Candidate frog origin, signed so a step below zero is caught
    always_comb begin
        frog_x_step = $signed({1'b0, frog_x}) + $signed({9'd0, key_right})
                      - $signed({9'd0, key_left});
        frog_y_step = $signed({1'b0, frog_y}) + $signed({9'd0, key_down})
                      - $signed({9'd0, key_up});
        frog_x_ok   = (frog_x_step >= 0) && (frog_x_step <= FROG_X_MAX);
        frog_y_ok   = (frog_y_step >= 0) && (frog_y_step <= FROG_Y_MAX);
    end

    // Motion applied once per pass, on the setup cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            frog_x    <= '0;
            frog_y    <= '0;
            river_1_x <= '0;
            river_2_x <= X_LAST;
            river_3_x <= '0;
        end else if (cmd.start) begin
            case (cmd.target)
                frogger_pkg::TGT_RIVER_1: river_1_x <= wrap_inc(river_1_x);
                frogger_pkg::TGT_RIVER_2: river_2_x <= wrap_dec(river_2_x);
                frogger_pkg::TGT_RIVER_3: river_3_x <= wrap_inc(river_3_x);
                frogger_pkg::TGT_FROG: begin
                    // Each axis held in place if the step leaves the screen
                    if (frog_x_ok)
                        frog_x <= frog_x_step[8:0];
                    if (frog_y_ok)
                        frog_y <= frog_y_step[8:0];
                end
                default: ;
            endcase
        end
    end

    // Rectangle lookup, full screen unless an object is selected
    always_comb begin
        rect.origin_x = '0;
        rect.origin_y = '0;
        rect.width    = frogger_pkg::coord_t'(SCREEN_W);
        rect.height   = frogger_pkg::coord_t'(SCREEN_H);
        rect.color    = frogger_pkg::COLOR_BG;
        if (cmd.target inside {frogger_pkg::TGT_RIVER_1, frogger_pkg::TGT_RIVER_2,
                               frogger_pkg::TGT_RIVER_3}) begin
            rect.width  = frogger_pkg::RIVER_W;
            rect.height = frogger_pkg::RIVER_H;
            rect.color  = frogger_pkg::COLOR_RIVER;
        end
        case (cmd.target)
            frogger_pkg::TGT_SCRN_START:     rect.color = frogger_pkg::COLOR_START;
            frogger_pkg::TGT_SCRN_GAME_OVER: rect.color = frogger_pkg::COLOR_GAME_OVER;
            frogger_pkg::TGT_RIVER_1: begin
                rect.origin_x = river_1_x;
                rect.origin_y = frogger_pkg::RIVER_1_Y;
            end
            frogger_pkg::TGT_RIVER_2: begin
                rect.origin_x = river_2_x;
                rect.origin_y = frogger_pkg::RIVER_2_Y;
            end
            frogger_pkg::TGT_RIVER_3: begin
                rect.origin_x = river_3_x;
                rect.origin_y = frogger_pkg::RIVER_3_Y;
            end
            frogger_pkg::TGT_FROG: begin
                rect.origin_x = frog_x;
                rect.origin_y = frog_y;
                rect.width    = frogger_pkg::FROG_W;
                rect.height   = frogger_pkg::FROG_H;
                rect.color    = frogger_pkg::COLOR_FROG;
            end
            default: ;
        endcase
    end

endmodule

// ==== src/rect_rasterizer.sv ====
`timescale 1ns/100ps

module rect_rasterizer #(
    parameter int SCREEN_W = 320
) (
    input  logic                clk,
    input  logic                reset,
    draw_cmd_if.rasterizer      cmd,
    rect_if.sink                rect,
    output logic                plot,
    output frogger_pkg::coord_t x,
    output frogger_pkg::coord_t y,
    output frogger_pkg::color_t color
);

    // Offset of the current pixel inside the rectangle
    frogger_pkg::coord_t col;
    frogger_pkg::coord_t row;
    logic                last_col;
    logic                last_row;
    // One extra bit so the wrap compare cannot overflow
    logic [9:0]          x_sum;
    frogger_pkg::coord_t x_wrap;

    assign last_col = (col == rect.width - 9'd1);
    assign last_row = (row == rect.height - 9'd1);

    // Last pixel of the rectangle
    assign cmd.done = cmd.active && last_col && last_row;

    // Columns run past the right edge back to column 0
    assign x_sum  = {1'b0, rect.origin_x} + {1'b0, col};
    assign x_wrap = (x_sum >= 10'(SCREEN_W)) ? 9'(x_sum - 10'(SCREEN_W)) : x_sum[8:0];

    // Scan order is x fastest, then down one row
    always_ff @(posedge clk) begin
        if (reset) begin
            col <= '0;
            row <= '0;
        end else if (cmd.start) begin
            col <= '0;
            row <= '0;
        end else if (cmd.active) begin
            if (last_col) begin
                col <= '0;
                row <= row + 9'd1;
            end else begin
                col <= col + 9'd1;
            end
        end
    end

    // Pixel stream is one cycle behind the counters
    always_ff @(posedge clk) begin
        if (reset)
            plot <= 1'b0;
        else
            plot <= cmd.active;
    end

    always_ff @(posedge clk) begin
        x     <= x_wrap;
        y     <= rect.origin_y + row;
        color <= rect.color;
    end

endmodule

// ==== src/frogger_top.sv ====
`timescale 1ns/100ps

module frogger_top #(
    parameter int SCREEN_W = 320,
    parameter int SCREEN_H = 240
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                go_key,
    input  logic                key_left,
    input  logic                key_right,
    input  logic                key_up,
    input  logic                key_down,
    output logic                plot,
    output frogger_pkg::coord_t x,
    output frogger_pkg::coord_t y,
    output frogger_pkg::color_t color
);

    // Draw command from the FSM, done back from the rasterizer
    draw_cmd_if cmd ();

    // Rectangle of the current target
    rect_if rect ();

    // Scene FSM and go key shaper
    scene_sequencer u_sequencer (
        .clk    (clk),
        .reset  (reset),
        .go_key (go_key),
        .cmd    (cmd)
    );

    // Frog and river positions
    object_store #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) u_store (
        .clk       (clk),
        .reset     (reset),
        .key_left  (key_left),
        .key_right (key_right),
        .key_up    (key_up),
        .key_down  (key_down),
        .cmd       (cmd),
        .rect      (rect)
    );

    // Pixel scan onto the plot stream
    rect_rasterizer #(
        .SCREEN_W (SCREEN_W)
    ) u_rasterizer (
        .clk   (clk),
        .reset (reset),
        .cmd   (cmd),
        .rect  (rect),
        .plot  (plot),
        .x     (x),
        .y     (y),
        .color (color)
    );

endmodule

// ==== test/frogger_sva.sv ====
`timescale 1ns/100ps

module frogger_sva #(
    parameter int SCREEN_W = 320,
    parameter int SCREEN_H = 240
) (
    input logic                clk,
    input logic                reset,
    input logic                plot,
    input frogger_pkg::coord_t x,
    input frogger_pkg::coord_t y,
    input logic                start,
    input logic                active,
    input logic                done
);

    // Set once the sequencer has issued its first command after reset
    logic left_wait;

    always_ff @(posedge clk) begin
        if (reset)
            left_wait <= 1'b0;
        else if (start)
            left_wait <= 1'b1;
    end

    // Every plotted pixel lands on the screen
    a_plot_on_screen: assert property (@(posedge clk) disable iff (reset)
        plot |-> (x < SCREEN_W) && (y < SCREEN_H))
        else $error("pixel plotted off screen");

    // Completion is a single cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done held for more than one cycle");

    // Setup cycle and pixel cycles never overlap
    a_start_not_active: assert property (@(posedge clk) disable iff (reset)
        !(start && active))
        else $error("start and active high together");

    // Nothing is drawn before the first go press
    a_no_early_plot: assert property (@(posedge clk) disable iff (reset)
        !left_wait |-> !plot)
        else $error("pixel plotted while waiting for the first go");

endmodule

bind frogger_top frogger_sva #(
    .SCREEN_W (SCREEN_W),
    .SCREEN_H (SCREEN_H)
) u_sva (
    .clk    (clk),
    .reset  (reset),
    .plot   (plot),
    .x      (x),
    .y      (y),
    .start  (cmd.start),
    .active (cmd.active),
    .done   (cmd.done)
);

// ==== test/frogger_tb.sv ====
`timescale 1ns/100ps

module frogger_tb;

    localparam int SCREEN_W = 320;
    localparam int SCREEN_H = 240;
    // Cycles allowed from a go press or a pass end to the next pixel
    localparam int PLOT_TIMEOUT = 50;

    logic clk;
    logic reset;
    logic go_key;
    logic key_left;
    logic key_right;
    logic key_up;
    logic key_down;
    logic plot;
    frogger_pkg::coord_t x;
    frogger_pkg::coord_t y;
    frogger_pkg::color_t color;

    // Reference frog origin and pass count
    int frog_x_m;
    int frog_y_m;
    int pass_n;
    logic [31:0] rng;

    frogger_top uut (
        .clk       (clk),
        .reset     (reset),
        .go_key    (go_key),
        .key_left  (key_left),
        .key_right (key_right),
        .key_up    (key_up),
        .key_down  (key_down),
        .plot      (plot),
        .x         (x),
        .y         (y),
        .color     (color)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp)
            fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_coord(string name, frogger_pkg::coord_t got, frogger_pkg::coord_t exp);
        if (got !== exp)
            fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_color(string name, frogger_pkg::color_t got, frogger_pkg::color_t exp);
        if (got !== exp)
            fail_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Two cycle press, short enough that no pixel is missed afterwards
    task automatic press_go();
        @(posedge clk);
        go_key <= 1'b1;
        repeat (2) @(posedge clk);
        go_key <= 1'b0;
    endtask

    // Key bits are left, right, up, down from bit 0
    task automatic set_keys(logic [3:0] k);
        @(posedge clk);
        key_left  <= k[0];
        key_right <= k[1];
        key_up    <= k[2];
        key_down  <= k[3];
    endtask

    // Outputs sampled on the falling edge, away from the register updates
    task automatic expect_quiet(int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_bit("plot", plot, 1'b0);
        end
    endtask

    task automatic wait_plot(string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (plot !== 1'b1) begin
            if (waited >= PLOT_TIMEOUT)
                fail_run($sformatf("no pixel stream appeared for %s", what));
            waited++;
            @(negedge clk);
        end
    endtask

    // One pass in raster order, x fastest, columns wrap past the right edge
    task automatic collect_pass(string what, int ox, int oy, int w, int h,
                                frogger_pkg::color_t c);
        wait_plot(what);
        for (int j = 0; j < h; j++) begin
            for (int i = 0; i < w; i++) begin
                check_bit("plot", plot, 1'b1);
                check_coord("x", x, frogger_pkg::coord_t'((ox + i) % SCREEN_W));
                check_coord("y", y, frogger_pkg::coord_t'(oy + j));
                check_color("color", color, c);
                @(negedge clk);
            end
        end
        // Stream drops right after the last pixel
        check_bit("plot", plot, 1'b0);
    endtask

    task automatic collect_bg();
        collect_pass("background", 0, 0, SCREEN_W, SCREEN_H, frogger_pkg::COLOR_BG);
    endtask

    // Rivers and frog of loop pass n, each moved once before it is drawn
    task automatic draw_pass_objects(int n);
        int r1;
        int r2;
        int nx;
        int ny;
        r1 = n % SCREEN_W;
        r2 = (2 * SCREEN_W - 1 - r1) % SCREEN_W;
        collect_pass("river 1", r1, frogger_pkg::RIVER_1_Y, frogger_pkg::RIVER_W,
                     frogger_pkg::RIVER_H, frogger_pkg::COLOR_RIVER);
        collect_pass("river 2", r2, frogger_pkg::RIVER_2_Y, frogger_pkg::RIVER_W,
                     frogger_pkg::RIVER_H, frogger_pkg::COLOR_RIVER);
        collect_pass("river 3", r1, frogger_pkg::RIVER_3_Y, frogger_pkg::RIVER_W,
                     frogger_pkg::RIVER_H, frogger_pkg::COLOR_RIVER);
        // Each axis stays put if its step would leave the screen
        nx = frog_x_m + int'(key_right) - int'(key_left);
        ny = frog_y_m + int'(key_down) - int'(key_up);
        if (nx >= 0 && nx <= SCREEN_W - int'(frogger_pkg::FROG_W))
            frog_x_m = nx;
        if (ny >= 0 && ny <= SCREEN_H - int'(frogger_pkg::FROG_H))
            frog_y_m = ny;
        collect_pass("frog", frog_x_m, frog_y_m, frogger_pkg::FROG_W,
                     frogger_pkg::FROG_H, frogger_pkg::COLOR_FROG);
    endtask

    task automatic test_start_screen();
        expect_quiet(200);
        // Go stays held into the next test
        @(posedge clk);
        go_key <= 1'b1;
        collect_pass("start screen", 0, 0, SCREEN_W, SCREEN_H, frogger_pkg::COLOR_START);
    endtask

    task automatic test_screen_sequence();
        expect_quiet(200);
        @(posedge clk);
        go_key <= 1'b0;
        expect_quiet(20);
        press_go();
        collect_pass("game over screen", 0, 0, SCREEN_W, SCREEN_H,
                     frogger_pkg::COLOR_GAME_OVER);
        press_go();
        collect_bg();
    endtask

    task automatic test_river_drift();
        for (int n = 1; n <= 3; n++) begin
            if (n > 1)
                collect_bg();
            draw_pass_objects(n);
        end
        pass_n = 3;
    endtask

    task automatic test_frog_moves();
        // Left and up held at the top left corner
        set_keys(4'b0101);
        pass_n++;
        collect_bg();
        draw_pass_objects(pass_n);
        repeat (6) begin
            rng = xorshift32(rng);
            set_keys(rng[3:0]);
            pass_n++;
            collect_bg();
            draw_pass_objects(pass_n);
        end
        // Right and down, so both axes leave the corner
        set_keys(4'b1010);
        pass_n++;
        collect_bg();
        draw_pass_objects(pass_n);
    endtask

    task automatic test_reset_mid_pass();
        set_keys(4'b0000);
        wait_plot("pass before reset");
        repeat (100) @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_bit("plot", plot, 1'b0);
        repeat (6) @(posedge clk);
        reset <= 1'b0;
        frog_x_m = 0;
        frog_y_m = 0;
        expect_quiet(200);
        press_go();
        collect_pass("start screen", 0, 0, SCREEN_W, SCREEN_H, frogger_pkg::COLOR_START);
        press_go();
        collect_pass("game over screen", 0, 0, SCREEN_W, SCREEN_H,
                     frogger_pkg::COLOR_GAME_OVER);
        press_go();
        collect_bg();
        draw_pass_objects(1);
    endtask

    initial begin
        reset     = 1'b1;
        go_key    = 1'b0;
        key_left  = 1'b0;
        key_right = 1'b0;
        key_up    = 1'b0;
        key_down  = 1'b0;
        rng       = 32'd40824;
        frog_x_m  = 0;
        frog_y_m  = 0;
        pass_n    = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        test_start_screen();
        test_screen_sequence();
        test_river_drift();
        test_frog_moves();
        test_reset_mid_pass();
        $display("test passed");
        $finish;
    end

endmodule

// ==== src.f ====
src/frogger_pkg.sv
src/draw_cmd_if.sv
src/rect_if.sv
src/scene_sequencer.sv
src/object_store.sv
src/rect_rasterizer.sv
src/frogger_top.sv
test/frogger_sva.sv
test/frogger_tb.sv
